/* dv/tb_mem.sv */
`timescale 1ns/1ps

module tb_mem
(
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    input  logic        i_we,
    input  logic [3:0]  i_sel,
    input  logic        i_stb,
    input  logic        i_cyc,
    output logic [31:0] o_dat,
    output logic        o_ack
);

    localparam int WORDS = 512;
    localparam logic [6:0] OP_IMM = 7'h13;
    localparam logic [6:0] OP_REG = 7'h33;
    localparam logic [6:0] OP_LOAD = 7'h03;
    localparam logic [6:0] OP_LUI = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_JALR = 7'h67;

    logic [31:0] mem [WORDS];
    logic [31:0] store_adr [$];
    int          seed;
    int          wait_left;
    logic        busy;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // word store relative to x10
    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd10, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    initial
    begin
        seed      = 64;
        o_ack     = 1'b0;
        o_dat     = '0;
        busy      = 1'b0;
        wait_left = 0;
        for (int i = 0; i < WORDS; i++)
            mem[i] = ~(32'(i) << 2) ^ 32'h5a5a_0000;
        mem[0]  = enc_i(12'h400, 5'd0, 3'd0, 5'd10, OP_IMM);
        mem[1]  = enc_i(12'hFFB, 5'd0, 3'd0, 5'd1, OP_IMM);
        mem[2]  = enc_i(12'd3, 5'd0, 3'd0, 5'd2, OP_IMM);
        mem[3]  = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
        mem[5]  = enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3);
        mem[7]  = enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3);
        mem[9]  = enc_i(12'd4, 5'd1, 3'd5, 5'd3, OP_IMM);
        mem[11] = enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3);
        mem[13] = enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd3);
        mem[15] = enc_i(12'h0F0, 5'd1, 3'd4, 5'd3, OP_IMM);
        for (int k = 0; k < 7; k++)
            mem[4 + 2 * k] = enc_sw(12'(k * 4), 5'd3);
        mem[17] = {20'h12345, 5'd4, OP_LUI};
        mem[18] = enc_sw(12'd28, 5'd4);
        mem[19] = {20'h00001, 5'd5, OP_AUIPC};
        mem[20] = enc_sw(12'd32, 5'd5);
        // taken branches skip a poison word
        mem[21] = enc_b(13'd8, 5'd1, 5'd1, 3'd0);
        mem[23] = enc_b(13'd8, 5'd2, 5'd1, 3'd0);
        mem[24] = enc_i(12'd1, 5'd7, 3'd0, 5'd7, OP_IMM);
        mem[25] = enc_b(13'd8, 5'd2, 5'd1, 3'd1);
        mem[27] = enc_b(13'd8, 5'd2, 5'd1, 3'd4);
        mem[29] = enc_b(13'd8, 5'd2, 5'd1, 3'd5);
        mem[30] = enc_i(12'd2, 5'd7, 3'd0, 5'd7, OP_IMM);
        mem[31] = enc_b(13'd8, 5'd2, 5'd1, 3'd6);
        mem[32] = enc_i(12'd4, 5'd7, 3'd0, 5'd7, OP_IMM);
        mem[33] = enc_b(13'd8, 5'd2, 5'd1, 3'd7);
        mem[35] = enc_j(21'd8, 5'd9);
        mem[22] = enc_i(12'h100, 5'd7, 3'd0, 5'd7, OP_IMM);
        mem[26] = mem[22];
        mem[28] = mem[22];
        mem[34] = mem[22];
        mem[36] = mem[22];
        mem[37] = enc_sw(12'd36, 5'd7);
        mem[38] = enc_sw(12'd40, 5'd9);
        mem[39] = enc_i(12'd196, 5'd0, 3'd0, 5'd11, OP_IMM);
        mem[40] = enc_i(12'd4, 5'd11, 3'd0, 5'd12, OP_JALR);
        mem[50] = enc_sw(12'd44, 5'd12);
        mem[51] = {20'hCAFEB, 5'd13, OP_LUI};
        mem[52] = enc_i(12'hABE, 5'd13, 3'd0, 5'd13, OP_IMM);
        mem[53] = enc_sw(12'd48, 5'd13);
        mem[54] = enc_i(12'd48, 5'd10, 3'b010, 5'd14, OP_LOAD);
        mem[55] = enc_sw(12'd52, 5'd14);
        mem[56] = enc_i(12'h055, 5'd0, 3'd0, 5'd15, OP_IMM);
        // fence and an undefined opcode that both name x15
        mem[57] = enc_i(12'h0FF, 5'd0, 3'd0, 5'd15, 7'h0F);
        mem[58] = {20'h12345, 5'd15, 7'h7F};
        mem[59] = enc_sw(12'd56, 5'd15);
        mem[60] = enc_j(21'd0, 5'd0);
    end

    // ack and read data change on the falling edge
    always @(negedge i_clk)
    begin
        if (!i_reset_n || o_ack)
        begin
            o_ack = 1'b0;
            busy  = 1'b0;
        end
        else if (i_cyc && i_stb)
        begin
            if (!busy)
            begin
                busy      = 1'b1;
                wait_left = {$random(seed)} % 4;
            end
            if (wait_left == 0)
            begin
                o_ack = 1'b1;
                if (i_we)
                begin
                    for (int b = 0; b < 4; b++)
                    begin
                        if (i_sel[b])
                            mem[i_adr[10:2]][8 * b +: 8] = i_dat[8 * b +: 8];
                    end
                    store_adr.push_back(i_adr);
                end
                else
                    o_dat = mem[i_adr[10:2]];
            end
            else
                wait_left--;
        end
    end

endmodule

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] RESET_ADDR = 32'h0000_0000;
    localparam logic [31:0] DATA_BASE  = 32'h0000_0400;
    localparam logic [31:0] END_ADDR   = 32'd240;
    localparam int          N_INSTR    = 61;
    localparam int          PERIOD     = 100;
    // at worst 4 fetch, 3 fixed and 4 data cycles per instruction
    localparam int          TIMEOUT    = N_INSTR * 11 * PERIOD * 2;
    localparam int          A_VAL      = -5;
    localparam int          B_VAL      = 3;
    localparam logic [31:0] UA         = 32'(A_VAL);
    localparam logic [31:0] UB         = 32'(B_VAL);
    localparam int          N_STORES   = 15;
    localparam int          T_RESET    = 0;
    localparam int          T_BUS      = 1;
    localparam int          T_ARITH    = 2;
    localparam int          T_FLOW     = 3;
    localparam int          T_MEM      = 4;
    localparam int          T_NOP      = 5;

    logic        clk;
    logic        rst_n;
    logic [31:0] rdat;
    logic        ack;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic        we;
    logic [3:0]  sel;
    logic        stb;
    logic        cyc;
    logic [31:0] exp_st [N_STORES];
    logic [31:0] exp_fetch;
    int          last_idx;
    int          st_k;
    int          errs [6];
    int          checks;
    logic        done;
    string       names [6] = '{"reset", "wishbone", "arith", "control", "load_store", "nop"};

    rv_core #(.RESET_ADDR(RESET_ADDR)) dut_i
    (
        .i_clk      (clk),
        .i_reset_n  (rst_n),
        .i_wb_dat   (rdat),
        .i_wb_ack   (ack),
        .o_wb_adr   (adr),
        .o_wb_dat   (wdat),
        .o_wb_we    (we),
        .o_wb_sel   (sel),
        .o_wb_stb   (stb),
        .o_wb_cyc   (cyc)
    );

    tb_mem mem_i
    (
        .i_clk      (clk),
        .i_reset_n  (rst_n),
        .i_adr      (adr),
        .i_dat      (wdat),
        .i_we       (we),
        .i_sel      (sel),
        .i_stb      (stb),
        .i_cyc      (cyc),
        .o_dat      (rdat),
        .o_ack      (ack)
    );

    task automatic mismatch(input int test, input string name, input logic [31:0] exp_v,
        input logic [31:0] act_v);
        errs[test]++;
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    task automatic failure(input int test, input string text);
        errs[test]++;
        $display("Error at %0t: %s", $time, text);
    endtask

    // targets of the taken branches and jumps in the program
    function automatic logic [31:0] next_fetch(input logic [31:0] a);
        case (int'(a >> 2))
            21:      return 32'd92;
            25:      return 32'd108;
            27:      return 32'd116;
            33:      return 32'd140;
            35:      return 32'd148;
            40:      return 32'd200;
            60:      return 32'd240;
            default: return a + 32'd4;
        endcase
    endfunction

    function automatic logic is_mem_op(input int idx);
        return (idx >= 4 && idx <= 20 && idx % 2 == 0) || idx == 37 || idx == 38 ||
               idx == 50 || (idx >= 53 && idx <= 55) || idx == 59;
    endfunction

    function automatic int store_test(input int k);
        return (k < 9) ? T_ARITH : (k < 12) ? T_FLOW : (k < 14) ? T_MEM : T_NOP;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    reset_fetch: assert property (@(posedge clk)
        $rose(rst_n) |-> (cyc && stb && !we && adr == RESET_ADDR))
        else failure(T_RESET, "first request after reset is wrong");

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stb && !ack) |=> (stb && cyc && adr == $past(adr) && wdat == $past(wdat) &&
                           we == $past(we) && sel == $past(sel)))
        else failure(T_BUS, "wishbone request changed while waiting for ack");

    stb_drop: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !stb)
        else failure(T_BUS, "strobe still high in the cycle after ack");

    sel_ones: assert property (@(posedge clk) disable iff (!rst_n) sel == 4'hF)
        else mismatch(T_BUS, "o_wb_sel", 32'hF, 32'(sel));

    always @(posedge clk)
    begin
        if (rst_n && cyc && stb && ack && !done)
        begin
            checks++;
            if (adr < DATA_BASE)
            begin
                fetch_addr: assert (adr == exp_fetch)
                    else mismatch(T_FLOW, "fetch o_wb_adr", exp_fetch, adr);
                last_idx  = int'(adr >> 2);
                exp_fetch = next_fetch(adr);
                if (adr == END_ADDR)
                    done = 1'b1;
            end
            else
            begin
                data_allowed: assert (is_mem_op(last_idx))
                    else failure(T_NOP, "data access after a non memory instruction");
                if (we && st_k < N_STORES)
                begin
                    store_adr: assert (adr == DATA_BASE + 32'(st_k * 4))
                        else mismatch(store_test(st_k), "store o_wb_adr",
                                      DATA_BASE + 32'(st_k * 4), adr);
                    store_dat: assert (wdat == exp_st[st_k])
                        else mismatch(store_test(st_k), "store o_wb_dat", exp_st[st_k], wdat);
                    st_k++;
                end
                else if (!we)
                begin
                    load_adr: assert (adr == DATA_BASE + 32'd48)
                        else mismatch(T_MEM, "load o_wb_adr", DATA_BASE + 32'd48, adr);
                end
            end
        end
    end

    initial
    begin
        #(TIMEOUT);
        $display("Error: run did not reach the end loop within %0d ns", TIMEOUT);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        int total;
        rst_n     = 1'b0;
        done      = 1'b0;
        exp_fetch = RESET_ADDR;
        last_idx  = 0;
        st_k      = 0;
        checks    = 0;
        total     = 0;
        for (int t = 0; t < 6; t++)
            errs[t] = 0;
        exp_st[0]  = UA + UB;
        exp_st[1]  = UA - UB;
        exp_st[2]  = 32'(A_VAL >>> B_VAL);
        exp_st[3]  = UA >> 4;
        exp_st[4]  = (A_VAL < B_VAL) ? 32'd1 : 32'd0;
        exp_st[5]  = (UA < UB) ? 32'd1 : 32'd0;
        exp_st[6]  = UA ^ 32'h0F0;
        exp_st[7]  = {20'h12345, 12'h000};
        exp_st[8]  = 32'd76 + {20'h00001, 12'h000};
        exp_st[9]  = 32'd7;
        exp_st[10] = 32'd35 * 4 + 4;
        exp_st[11] = 32'd40 * 4 + 4;
        exp_st[12] = {20'hCAFEB, 12'h000} + 32'(-1346);
        exp_st[13] = exp_st[12];
        exp_st[14] = 32'h55;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        wait (done);
        @(negedge clk);
        checks++;
        store_count: assert (mem_i.store_adr.size() == N_STORES)
            else mismatch(T_MEM, "store count", N_STORES, mem_i.store_adr.size());
        for (int t = 0; t < 6; t++)
        begin
            $display("test %s: %s, %0d errors", names[t], (errs[t] == 0) ? "ok" : "bad", errs[t]);
            total += errs[t];
        end
        $display("%0d checks, %0d errors", checks, total);
        if (total == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu
(
    input  logic [rv_pkg::XLEN-1:0]         i_src_a,
    input  logic [rv_pkg::XLEN-1:0]         i_src_b,
    input  logic [rv_pkg::ALU_CTRL_W-1:0]   i_ctrl,
    output logic [rv_pkg::XLEN-1:0]         o_result
);

    logic [4:0]              shamt;
    logic [rv_pkg::XLEN-1:0] sra_res;
    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt   = i_src_b[4:0];
    assign sra_res = $signed(i_src_a) >>> shamt;
    assign eq      = i_src_a == i_src_b;
    assign lt_s    = $signed(i_src_a) < $signed(i_src_b);
    assign lt_u    = i_src_a < i_src_b;

    // compares land in bit 0, used for both branches and slt
    always_comb
    begin
        o_result = '0;
        case (i_ctrl[3:0])
            rv_pkg::ALU_ADD:  o_result = i_src_a + i_src_b;
            rv_pkg::ALU_SUB:  o_result = i_src_a - i_src_b;
            rv_pkg::ALU_XOR:  o_result = i_src_a ^ i_src_b;
            rv_pkg::ALU_OR:   o_result = i_src_a | i_src_b;
            rv_pkg::ALU_AND:  o_result = i_src_a & i_src_b;
            rv_pkg::ALU_SHL:  o_result = i_src_a << shamt;
            rv_pkg::ALU_SHR:  o_result = i_ctrl[4] ? sra_res : (i_src_a >> shamt);
            rv_pkg::ALU_EQ:   o_result[0] = eq;
            rv_pkg::ALU_NEQ:  o_result[0] = !eq;
            rv_pkg::ALU_LTS:  o_result[0] = lt_s;
            rv_pkg::ALU_LTU:  o_result[0] = lt_u;
            rv_pkg::ALU_NLTS: o_result[0] = !lt_s;
            rv_pkg::ALU_NLTU: o_result[0] = !lt_u;
            default:          o_result = '0;
        endcase
    end

endmodule

/* rtl/rv_control.sv */
`timescale 1ns/1ps

module rv_control
(
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_wb_ack,
    input  logic    i_is_load,
    input  logic    i_is_store,
    output logic    o_wb_cyc,
    output logic    o_wb_stb,
    output logic    o_wb_we,
    output logic    o_ir_load,
    output logic    o_data_phase,
    output logic    o_reg_we_phase,
    output logic    o_pc_update
);

    logic [rv_pkg::PHASE_W-1:0] phase;
    logic [rv_pkg::PHASE_W-1:0] phase_nxt;
    logic                       bus_phase;

    always_comb
    begin
        case (phase)
            rv_pkg::PH_FETCH:
                phase_nxt = i_wb_ack ? rv_pkg::PH_DECODE : rv_pkg::PH_FETCH;
            rv_pkg::PH_DECODE:
                phase_nxt = rv_pkg::PH_EXEC;
            rv_pkg::PH_EXEC:
                phase_nxt = (i_is_load || i_is_store) ? rv_pkg::PH_DATA : rv_pkg::PH_WRITE;
            rv_pkg::PH_DATA:
                phase_nxt = i_wb_ack ? rv_pkg::PH_WRITE : rv_pkg::PH_DATA;
            rv_pkg::PH_WRITE:
                phase_nxt = rv_pkg::PH_FETCH;
            default:
                phase_nxt = rv_pkg::PH_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            phase <= rv_pkg::PH_FETCH;
        else
            phase <= phase_nxt;
    end

    // request held from phase entry until ack moves the phase on
    assign bus_phase = (phase == rv_pkg::PH_FETCH) || (phase == rv_pkg::PH_DATA);
    assign o_wb_cyc  = bus_phase;
    assign o_wb_stb  = bus_phase;
    assign o_wb_we   = (phase == rv_pkg::PH_DATA) && i_is_store;

    assign o_ir_load      = (phase == rv_pkg::PH_FETCH) && i_wb_ack;
    assign o_data_phase   = phase == rv_pkg::PH_DATA;
    assign o_reg_we_phase = phase == rv_pkg::PH_WRITE;
    assign o_pc_update    = phase == rv_pkg::PH_WRITE;

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core
#(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic [rv_pkg::XLEN-1:0]     i_wb_dat,
    input  logic                        i_wb_ack,
    output logic [rv_pkg::XLEN-1:0]     o_wb_adr,
    output logic [rv_pkg::XLEN-1:0]     o_wb_dat,
    output logic                        o_wb_we,
    output logic [3:0]                  o_wb_sel,
    output logic                        o_wb_stb,
    output logic                        o_wb_cyc
);

    logic [rv_pkg::XLEN-1:0]        pc;
    logic [rv_pkg::XLEN-1:0]        pc_plus4;
    rv_pkg::instr_u                 ir;
    logic [rv_pkg::XLEN-1:0]        load_data;
    logic [rv_pkg::REG_ADDR_W-1:0]  rs1;
    logic [rv_pkg::REG_ADDR_W-1:0]  rs2;
    logic [rv_pkg::REG_ADDR_W-1:0]  rd;
    logic [rv_pkg::XLEN-1:0]        imm;
    logic [rv_pkg::ALU_CTRL_W-1:0]  alu_ctrl;
    logic                           op1_pc;
    logic                           op2_imm;
    logic [1:0]                     res_src;
    logic                           reg_write;
    logic                           is_load;
    logic                           is_store;
    logic                           is_branch;
    logic                           is_jal;
    logic                           is_jalr;
    logic                           ir_load;
    logic                           data_phase;
    logic                           reg_we_phase;
    logic                           pc_update;
    logic [rv_pkg::XLEN-1:0]        rs1_data;
    logic [rv_pkg::XLEN-1:0]        rs2_data;
    logic [rv_pkg::XLEN-1:0]        src_a;
    logic [rv_pkg::XLEN-1:0]        src_b;
    logic [rv_pkg::XLEN-1:0]        alu_result;
    logic [rv_pkg::XLEN-1:0]        target;
    logic                           take;
    logic [rv_pkg::XLEN-1:0]        wb_data;

    rv_control
    control_i
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_wb_ack           (i_wb_ack),
        .i_is_load          (is_load),
        .i_is_store         (is_store),
        .o_wb_cyc           (o_wb_cyc),
        .o_wb_stb           (o_wb_stb),
        .o_wb_we            (o_wb_we),
        .o_ir_load          (ir_load),
        .o_data_phase       (data_phase),
        .o_reg_we_phase     (reg_we_phase),
        .o_pc_update        (pc_update)
    );

    rv_decoder
    decoder_i
    (
        .i_instr            (ir),
        .o_rs1              (rs1),
        .o_rs2              (rs2),
        .o_rd               (rd),
        .o_imm              (imm),
        .o_alu_ctrl         (alu_ctrl),
        .o_op1_pc           (op1_pc),
        .o_op2_imm          (op2_imm),
        .o_res_src          (res_src),
        .o_reg_write        (reg_write),
        .o_is_load          (is_load),
        .o_is_store         (is_store),
        .o_is_branch        (is_branch),
        .o_is_jal           (is_jal),
        .o_is_jalr          (is_jalr)
    );

    assign src_a = op1_pc ? pc : rs1_data;
    assign src_b = op2_imm ? imm : rs2_data;

    rv_alu
    alu_i
    (
        .i_src_a            (src_a),
        .i_src_b            (src_b),
        .i_ctrl             (alu_ctrl),
        .o_result           (alu_result)
    );

    rv_regs
    regs_i
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_rs1              (rs1),
        .i_rs2              (rs2),
        .i_rd               (rd),
        .i_write            (reg_write && reg_we_phase),
        .i_data             (wb_data),
        .o_data1            (rs1_data),
        .o_data2            (rs2_data)
    );

    // jalr clears bit 0 of its target
    assign pc_plus4 = pc + 32'd4;
    assign target   = ((is_jalr ? rs1_data : pc) + imm) & ~32'd1;
    assign take     = is_jal || is_jalr || (is_branch && alu_result[0]);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= RESET_ADDR;
        else if (pc_update)
            pc <= take ? target : pc_plus4;
    end

    // zero word decodes as a no-op until the first fetch lands
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            ir <= '0;
        else if (ir_load)
            ir <= i_wb_dat;
    end

    always_ff @(posedge i_clk)
    begin
        if (data_phase && i_wb_ack)
            load_data <= i_wb_dat;
    end

    always_comb
    begin
        case (res_src)
            rv_pkg::RES_MEM: wb_data = load_data;
            rv_pkg::RES_PC4: wb_data = pc_plus4;
            default:         wb_data = alu_result;
        endcase
    end

    assign o_wb_adr = data_phase ? alu_result : pc;
    assign o_wb_dat = rs2_data;
    assign o_wb_sel = 4'b1111;

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder
(
    input  rv_pkg::instr_u                  i_instr,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rd,
    output logic [rv_pkg::XLEN-1:0]         o_imm,
    output logic [rv_pkg::ALU_CTRL_W-1:0]   o_alu_ctrl,
    output logic                            o_op1_pc,
    output logic                            o_op2_imm,
    output logic [1:0]                      o_res_src,
    output logic                            o_reg_write,
    output logic                            o_is_load,
    output logic                            o_is_store,
    output logic                            o_is_branch,
    output logic                            o_is_jal,
    output logic                            o_is_jalr
);

    logic [4:0] opc;
    logic       full;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_alt;
    logic       is_op_imm;
    logic       is_op;
    logic       is_lui;
    logic       is_auipc;
    logic       is_shr;
    logic [3:0] alu_op;

    assign opc    = i_instr.r_fmt.opcode[6:2];
    assign full   = i_instr.r_fmt.opcode[1:0] == rv_pkg::OPC_FULL;
    assign funct3 = i_instr.i_fmt.funct3;
    assign funct7 = i_instr.r_fmt.funct7;
    assign is_alt = funct7 == 7'b0100000;

    // shift immediates carry funct7 in imm[11:5]
    assign is_op_imm = full && (opc == rv_pkg::OPC_OP_IMM) &&
        ((funct3 == 3'b001) ? (funct7 == 7'b0) :
         (funct3 == 3'b101) ? (funct7 == 7'b0 || is_alt) : 1'b1);
    assign is_op = full && (opc == rv_pkg::OPC_OP) &&
        (funct7 == 7'b0 || (is_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign is_lui      = full && (opc == rv_pkg::OPC_LUI);
    assign is_auipc    = full && (opc == rv_pkg::OPC_AUIPC);
    assign o_is_load   = full && (opc == rv_pkg::OPC_LOAD) && (funct3 == 3'b010);
    assign o_is_store  = full && (opc == rv_pkg::OPC_STORE) && (i_instr.s_fmt.funct3 == 3'b010);
    assign o_is_branch = full && (opc == rv_pkg::OPC_BRANCH) && (i_instr.b_fmt.funct3[2:1] != 2'b01);
    assign o_is_jalr   = full && (opc == rv_pkg::OPC_JALR) && (funct3 == 3'b000);
    assign o_is_jal    = full && (opc == rv_pkg::OPC_JAL);

    assign o_rs1 = is_lui ? '0 : i_instr.r_fmt.rs1;
    assign o_rs2 = i_instr.r_fmt.rs2;
    assign o_rd  = i_instr.r_fmt.rd;

    always_comb
    begin
        if (is_lui || is_auipc)
            o_imm = {i_instr.u_fmt.imm_31_12, 12'b0};
        else if (o_is_jal)
            o_imm = {{11{i_instr.j_fmt.imm_20}}, i_instr.j_fmt.imm_20, i_instr.j_fmt.imm_19_12,
                     i_instr.j_fmt.imm_11, i_instr.j_fmt.imm_10_1, 1'b0};
        else if (o_is_branch)
            o_imm = {{19{i_instr.b_fmt.imm_12}}, i_instr.b_fmt.imm_12, i_instr.b_fmt.imm_11,
                     i_instr.b_fmt.imm_10_5, i_instr.b_fmt.imm_4_1, 1'b0};
        else if (o_is_store)
            o_imm = {{20{i_instr.s_fmt.imm_11_5[6]}}, i_instr.s_fmt.imm_11_5,
                     i_instr.s_fmt.imm_4_0};
        else
            o_imm = {{20{i_instr.i_fmt.imm_11_0[11]}}, i_instr.i_fmt.imm_11_0};
    end

    always_comb
    begin
        alu_op = rv_pkg::ALU_ADD;
        if (o_is_branch)
        begin
            case (funct3)
                3'b000:  alu_op = rv_pkg::ALU_EQ;
                3'b001:  alu_op = rv_pkg::ALU_NEQ;
                3'b100:  alu_op = rv_pkg::ALU_LTS;
                3'b101:  alu_op = rv_pkg::ALU_NLTS;
                3'b110:  alu_op = rv_pkg::ALU_LTU;
                default: alu_op = rv_pkg::ALU_NLTU;
            endcase
        end
        else if (is_op || is_op_imm)
        begin
            case (funct3)
                3'b000:  alu_op = (is_op && is_alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'b001:  alu_op = rv_pkg::ALU_SHL;
                3'b010:  alu_op = rv_pkg::ALU_LTS;
                3'b011:  alu_op = rv_pkg::ALU_LTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = rv_pkg::ALU_SHR;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    assign is_shr     = (is_op || is_op_imm) && (funct3 == 3'b101);
    assign o_alu_ctrl = {is_shr && is_alt, alu_op};

    assign o_op1_pc  = is_auipc;
    assign o_op2_imm = !(is_op || o_is_branch);

    always_comb
    begin
        if (o_is_load)
            o_res_src = rv_pkg::RES_MEM;
        else if (o_is_jal || o_is_jalr)
            o_res_src = rv_pkg::RES_PC4;
        else
            o_res_src = rv_pkg::RES_ALU;
    end

    // unknown encodings fall out of every term and become no-ops
    assign o_reg_write = o_is_load || is_op_imm || is_op || is_lui || is_auipc ||
                         o_is_jal || o_is_jalr;

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_CTRL_W = 5;
    localparam int PHASE_W    = 3;

    // major opcodes, bits [6:2] of the word
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [1:0] OPC_FULL   = 2'b11;

    // alu operations, the arithmetic shift flag sits above these
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_XOR  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_AND  = 4'd4;
    localparam logic [3:0] ALU_SHL  = 4'd5;
    localparam logic [3:0] ALU_SHR  = 4'd6;
    localparam logic [3:0] ALU_EQ   = 4'd8;
    localparam logic [3:0] ALU_NEQ  = 4'd9;
    localparam logic [3:0] ALU_LTS  = 4'd10;
    localparam logic [3:0] ALU_LTU  = 4'd11;
    localparam logic [3:0] ALU_NLTS = 4'd12;
    localparam logic [3:0] ALU_NLTU = 4'd13;

    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    // instruction phases of the sequencer
    localparam logic [PHASE_W-1:0] PH_FETCH  = 3'd0;
    localparam logic [PHASE_W-1:0] PH_DECODE = 3'd1;
    localparam logic [PHASE_W-1:0] PH_EXEC   = 3'd2;
    localparam logic [PHASE_W-1:0] PH_DATA   = 3'd3;
    localparam logic [PHASE_W-1:0] PH_WRITE  = 3'd4;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

/* rtl/rv_regs.sv */
`timescale 1ns/1ps

module rv_regs
(
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   i_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   i_rd,
    input  logic                            i_write,
    input  logic [rv_pkg::XLEN-1:0]         i_data,
    output logic [rv_pkg::XLEN-1:0]         o_data1,
    output logic [rv_pkg::XLEN-1:0]         o_data2
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (i_write && (i_rd != '0))
            regs[i_rd] <= i_data;
    end

    // x0 reads as zero
    assign o_data1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_data2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_rv_core -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

/* sim.f */
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regs.sv
rtl/rv_decoder.sv
rtl/rv_control.sv
rtl/rv_core.sv
dv/tb_mem.sv
dv/tb_rv_core.sv
